// File: list.f
+incdir+hw
hw/daq_pkg.sv
hw/zynq_spi_slave.sv
hw/daq_ctrl_regs.sv
hw/adc_cfg_master.sv
hw/daq_top.sv
testbench/daq_top_sva.sv
testbench/tb_daq_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_daq_top
RTL_TOP ?= daq_top
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
PASS_MSG ?= === PASS ===
RTL_SRCS ?= hw/daq_pkg.sv hw/zynq_spi_slave.sv hw/daq_ctrl_regs.sv \
	hw/adc_cfg_master.sv hw/daq_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -Ihw --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_daq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "daq_defines.svh"

module tb_daq_top;

	// sck half period in sysclk cycles
	localparam int SPI_HALF = 8;
	// about 15 spi transfers of ~300 cycles, 8 adc frames of ~200,
	// quiet windows of 400, so ~7000 cycles, kept with a wide margin
	localparam int TIMEOUT_CYCLES = 60000;

	logic sysclk;
	logic rst;
	logic spi_ss;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_miso;
	logic pmt_trigger;
	logic trigger_out;
	logic adc_sclk_a;
	logic adc_ncs_a;
	logic adc_sdio_a;
	logic adc_sclk_b;
	logic adc_ncs_b;
	logic adc_sdio_b;

	int seed;
	int cycles;
	int errors;
	int checks;
	int tests;
	int err_mark;
	int pulses;
	logic [`DAQ_ADC_FRAME_BITS-1:0] frame_a;
	logic [`DAQ_ADC_FRAME_BITS-1:0] frame_b;
	daq_pkg::spi_byte_t rd_val;
	daq_pkg::adc_mode_t mode_val;
	daq_pkg::adc_mode_t new_mode;

	daq_top i_daq_top (
		.sysclk(sysclk),
		.rst(rst),
		.spi_ss(spi_ss),
		.spi_sclk(spi_sclk),
		.spi_mosi(spi_mosi),
		.spi_miso(spi_miso),
		.pmt_trigger(pmt_trigger),
		.trigger_out(trigger_out),
		.adc_sclk_a(adc_sclk_a),
		.adc_ncs_a(adc_ncs_a),
		.adc_sdio_a(adc_sdio_a),
		.adc_sclk_b(adc_sclk_b),
		.adc_ncs_b(adc_ncs_b),
		.adc_sdio_b(adc_sdio_b)
	);

	initial begin
		sysclk = 1'b0;
		forever #2 sysclk = ~sysclk;
	end

	// run limit
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge sysclk);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	// ------------------------------
	// checks and reporting
	// ------------------------------
	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act == exp) else begin
			$display("** Error %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic test_done(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
		end
	endtask

	// write frame as the adc expects it, msb first
	// rw 0, length 00, 13 bit register address, then the data byte
	function automatic logic [`DAQ_ADC_FRAME_BITS-1:0] expected_frame(
		input daq_pkg::adc_mode_t mode);
		return {1'b0, 2'b00, `DAQ_ADC_MODE_ADDR, mode};
	endfunction

	task automatic check_frames(input string name, input daq_pkg::adc_mode_t mode);
		check_val({name, " adc a"}, 32'(expected_frame(mode)), 32'(frame_a));
		check_val({name, " adc b"}, 32'(expected_frame(mode)), 32'(frame_b));
	endtask

	// ------------------------------
	// spi host, mode 0
	// ------------------------------
	task automatic spi_xfer(input logic [15:0] mosi_word, output daq_pkg::spi_byte_t rd_byte);
		logic [15:0] miso_word;
		miso_word = '0;
		@(negedge sysclk);
		spi_ss = 1'b0;
		repeat (SPI_HALF) @(negedge sysclk);
		for (int i = 15; i >= 0; i--) begin
			// mosi moves while sck is low
			spi_mosi = mosi_word[i];
			repeat (SPI_HALF) @(negedge sysclk);
			miso_word[i] = spi_miso;
			spi_sclk = 1'b1;
			repeat (SPI_HALF) @(negedge sysclk);
			spi_sclk = 1'b0;
		end
		repeat (SPI_HALF) @(negedge sysclk);
		spi_ss = 1'b1;
		// idle gap so the slave realigns
		repeat (2 * SPI_HALF) @(negedge sysclk);
		// second byte carries the read data
		rd_byte = miso_word[7:0];
	endtask

	task automatic reg_write(input daq_pkg::reg_addr_t addr, input daq_pkg::spi_byte_t val);
		daq_pkg::spi_cmd_t cmd;
		daq_pkg::spi_byte_t ignored;
		cmd.addr = addr;
		cmd.op = `DAQ_CMD_WRITE;
		spi_xfer({cmd, val}, ignored);
	endtask

	task automatic reg_read(input daq_pkg::reg_addr_t addr, output daq_pkg::spi_byte_t val);
		daq_pkg::spi_cmd_t cmd;
		cmd.addr = addr;
		cmd.op = `DAQ_CMD_READ;
		// dummy data byte of zeros
		spi_xfer({cmd, 8'h00}, val);
	endtask

	// ------------------------------
	// adc frame decoder
	// ------------------------------
	task automatic adc_capture(input logic chan_b,
		output logic [`DAQ_ADC_FRAME_BITS-1:0] frame);
		logic [`DAQ_ADC_FRAME_BITS-1:0] bits;
		bits = '0;
		if (chan_b) begin
			wait (adc_ncs_b == 1'b0);
		end else begin
			wait (adc_ncs_a == 1'b0);
		end
		// sdio is steady at rising sclk
		for (int i = `DAQ_ADC_FRAME_BITS - 1; i >= 0; i--) begin
			if (chan_b) begin
				@(posedge adc_sclk_b);
				bits[i] = adc_sdio_b;
			end else begin
				@(posedge adc_sclk_a);
				bits[i] = adc_sdio_a;
			end
		end
		// frame is over once ncs is back up
		if (chan_b) begin
			wait (adc_ncs_b == 1'b1);
		end else begin
			wait (adc_ncs_a == 1'b1);
		end
		frame = bits;
	endtask

	task automatic wait_adc_idle();
		@(negedge sysclk);
		while (!adc_ncs_a || !adc_ncs_b) begin
			@(negedge sysclk);
		end
	endtask

	// no chip select on either port for n cycles
	task automatic expect_quiet(input string name, input int n);
		int lows;
		lows = 0;
		repeat (n) begin
			@(negedge sysclk);
			if (!adc_ncs_a || !adc_ncs_b) begin
				lows++;
			end
		end
		checks++;
		assert (lows == 0) else begin
			$display("%s: an ADC frame started although the mode did not change", name);
			errors++;
		end
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	initial begin
		seed = 32'h2917;
		errors = 0;
		checks = 0;
		tests = 0;
		rst = 1'b1;
		spi_ss = 1'b1;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		pmt_trigger = 1'b0;
		repeat (10) @(negedge sysclk);
		rst = 1'b0;

		// one default frame per port after reset
		err_mark = errors;
		fork
			adc_capture(1'b0, frame_a);
			adc_capture(1'b1, frame_b);
		join
		check_frames("reset frame", `DAQ_ADC_MODE_DEFAULT);
		expect_quiet("after reset frame", 400);
		test_done("reset_frames", err_mark);

		err_mark = errors;
		mode_val = 8'($random(seed));
		reg_write(`DAQ_REG_ADC_MODE, mode_val);
		reg_read(`DAQ_REG_ADC_MODE, rd_val);
		check_val("mode readback", 32'(mode_val), 32'(rd_val));
		// address 3 holds nothing
		reg_read(4'd3, rd_val);
		check_val("unused address", 32'h0, 32'(rd_val));
		test_done("mode_readback", err_mark);

		// xor with a nonzero mask, always a real change
		err_mark = errors;
		wait_adc_idle();
		new_mode = mode_val ^ 8'h5A;
		fork
			reg_write(`DAQ_REG_ADC_MODE, new_mode);
			adc_capture(1'b0, frame_a);
			adc_capture(1'b1, frame_b);
		join
		check_frames("mode change", new_mode);
		reg_write(`DAQ_REG_ADC_MODE, new_mode);
		expect_quiet("same mode rewrite", 400);
		test_done("mode_change", err_mark);

		// ready_b and ready_a both set
		err_mark = errors;
		wait_adc_idle();
		reg_read(`DAQ_REG_STATUS, rd_val);
		check_val("status idle", 32'h03, 32'(rd_val));
		test_done("status", err_mark);

		err_mark = errors;
		@(negedge sysclk);
		pmt_trigger = 1'b1;
		@(negedge sysclk);
		pmt_trigger = 1'b0;
		pulses = 0;
		repeat (8) begin
			@(negedge sysclk);
			if (trigger_out) begin
				pulses++;
			end
		end
		check_val("pmt pulse width", 32'd1, 32'(pulses));
		reg_write(`DAQ_REG_TRIGGER, 8'h01);
		check_val("soft trigger set", 32'd1, 32'(trigger_out));
		pulses = 0;
		repeat (50) begin
			@(negedge sysclk);
			if (!trigger_out) begin
				pulses++;
			end
		end
		check_val("soft trigger held low cycles", 32'd0, 32'(pulses));
		reg_write(`DAQ_REG_TRIGGER, 8'h00);
		check_val("soft trigger cleared", 32'd0, 32'(trigger_out));
		test_done("trigger", err_mark);

		// bit 7 set keeps it away from the default
		err_mark = errors;
		mode_val = 8'($random(seed)) | 8'h80;
		reg_write(`DAQ_REG_ADC_MODE, mode_val);
		wait_adc_idle();
		fork
			reg_write(`DAQ_REG_SOFT_RESET, 8'h01);
			adc_capture(1'b0, frame_a);
			adc_capture(1'b1, frame_b);
		join
		check_frames("soft reset frame", `DAQ_ADC_MODE_DEFAULT);
		reg_read(`DAQ_REG_ADC_MODE, rd_val);
		check_val("mode after soft reset", 32'(`DAQ_ADC_MODE_DEFAULT), 32'(rd_val));
		test_done("soft_reset", err_mark);

		$display("tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
			tests, checks, errors, i_daq_top.u_sva.fail_cnt);
		if (errors == 0 && i_daq_top.u_sva.fail_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/daq_top_sva.sv
`timescale 1ns/1ps
`default_nettype none

module daq_top_sva (
	input wire logic sysclk,
	input wire logic rst_int,
	input wire logic pmt_trigger,
	input wire logic soft_trig,
	input wire logic trigger_out,
	input wire logic ready_a,
	input wire logic ready_b,
	input wire logic adc_ncs_a,
	input wire logic adc_ncs_b,
	input wire logic adc_sclk_a,
	input wire logic adc_sclk_b
);

	// read by the testbench at the end
	int fail_cnt = 0;

	// a selected adc is never ready
	a_ncs_ready: assert property (@(posedge sysclk) disable iff (rst_int)
		(adc_ncs_a || !ready_a) && (adc_ncs_b || !ready_b))
		else begin
			fail_cnt++;
			$error("adc chip select low while ready is high");
		end

	// serial clock parked low between frames
	a_sclk_idle: assert property (@(posedge sysclk) disable iff (rst_int)
		(!adc_ncs_a || !adc_sclk_a) && (!adc_ncs_b || !adc_sclk_b))
		else begin
			fail_cnt++;
			$error("adc sclk high while chip select is high");
		end

	// two flop trigger path, only once both flops left reset
	a_trigger_delay: assert property (@(posedge sysclk) disable iff (rst_int)
		!$past(rst_int, 1) && !$past(rst_int, 2)
		|-> trigger_out == $past(pmt_trigger | soft_trig, 2))
		else begin
			fail_cnt++;
			$error("trigger_out does not follow the trigger inputs by two cycles");
		end

	// board or soft reset deselects both adcs
	a_reset_ncs: assert property (@(posedge sysclk) rst_int |=> adc_ncs_a && adc_ncs_b)
		else begin
			fail_cnt++;
			$error("adc chip select low right after reset");
		end

endmodule

bind daq_top daq_top_sva u_sva (
	.sysclk(sysclk),
	.rst_int(rst_int),
	.pmt_trigger(pmt_trigger),
	.soft_trig(u_ctrl_regs.trig_reg),
	.trigger_out(trigger_out),
	.ready_a(ready_a),
	.ready_b(ready_b),
	.adc_ncs_a(adc_ncs_a),
	.adc_ncs_b(adc_ncs_b),
	.adc_sclk_a(adc_sclk_a),
	.adc_sclk_b(adc_sclk_b)
);

`default_nettype wire

// File: hw/daq_top.sv
`timescale 1ns/1ps
`default_nettype none

module daq_top (
	input wire logic sysclk,
	input wire logic rst,
	input wire logic spi_ss,
	input wire logic spi_sclk,
	input wire logic spi_mosi,
	output logic spi_miso,
	input wire logic pmt_trigger,
	output logic trigger_out,
	output logic adc_sclk_a,
	output logic adc_ncs_a,
	output logic adc_sdio_a,
	output logic adc_sclk_b,
	output logic adc_ncs_b,
	output logic adc_sdio_b
);

	// board reset merged with the host soft reset
	logic rst_int;
	logic soft_rst;
	// host link
	daq_pkg::spi_byte_t rx_byte;
	daq_pkg::spi_byte_t tx_byte;
	logic rx_done;
	// adc side
	daq_pkg::adc_mode_t adc_mode;
	daq_pkg::adc_status_t adc_status;
	logic ready_a;
	logic ready_b;

	assign rst_int = rst | soft_rst;

	// ------------------------------
	// host spi and registers
	// ------------------------------
	zynq_spi_slave u_spi_slave (
		.sysclk(sysclk),
		.rst(rst_int),
		.ss(spi_ss),
		.sck(spi_sclk),
		.mosi(spi_mosi),
		.miso(spi_miso),
		.tx_byte(tx_byte),
		.rx_byte(rx_byte),
		.rx_done(rx_done)
	);

	daq_ctrl_regs u_ctrl_regs (
		.sysclk(sysclk),
		.rst(rst_int),
		.rx_byte(rx_byte),
		.rx_done(rx_done),
		.ss(spi_ss),
		.tx_byte(tx_byte),
		.adc_status(adc_status),
		.adc_mode(adc_mode),
		.soft_rst(soft_rst),
		.pmt_trigger(pmt_trigger),
		.trigger_out(trigger_out)
	);

	// status bits for register 13
	assign adc_status.ready_a = ready_a;
	assign adc_status.ready_b = ready_b;

	// ------------------------------
	// one config master per octal adc
	// ------------------------------
	adc_cfg_master u_adc_cfg_a (
		.sysclk(sysclk),
		.rst(rst_int),
		.adc_mode(adc_mode),
		.ready(ready_a),
		.adc_sclk(adc_sclk_a),
		.adc_ncs(adc_ncs_a),
		.adc_sdio(adc_sdio_a)
	);

	adc_cfg_master u_adc_cfg_b (
		.sysclk(sysclk),
		.rst(rst_int),
		.adc_mode(adc_mode),
		.ready(ready_b),
		.adc_sclk(adc_sclk_b),
		.adc_ncs(adc_ncs_b),
		.adc_sdio(adc_sdio_b)
	);

endmodule

`default_nettype wire

// File: hw/adc_cfg_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "daq_defines.svh"

module adc_cfg_master (
	input wire logic sysclk,
	input wire logic rst,
	input wire daq_pkg::adc_mode_t adc_mode,
	output logic ready,
	output logic adc_sclk,
	output logic adc_ncs,
	output logic adc_sdio
);

	localparam int BITS = `DAQ_ADC_FRAME_BITS;
	localparam int HALF = `DAQ_ADC_SCLK_HALF;
	localparam int DIV_W = $clog2(HALF);
	localparam int BIT_W = $clog2(BITS);

	daq_pkg::cfg_state_t state;
	// last mode sent to the adc
	daq_pkg::adc_mode_t mode_q;
	daq_pkg::adc_frame_t frame_new;
	logic [BITS-1:0] frame_sr;
	logic [DIV_W-1:0] div_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic mode_diff;
	logic half_done;

	assign mode_diff = (adc_mode != mode_q);
	assign half_done = (div_cnt == DIV_W'(HALF - 1));

	// ------------------------------
	// frame for the new mode
	// ------------------------------
	always_comb begin
		frame_new.rw = 1'b0;
		frame_new.len = 2'b00;
		frame_new.addr = `DAQ_ADC_MODE_ADDR;
		frame_new.data = adc_mode;
	end

	// ------------------------------
	// change detect and shifter
	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (rst) begin
			state <= daq_pkg::CFG_IDLE;
			// forces one frame right after reset
			mode_q <= `DAQ_ADC_MODE_RESET;
			ready <= 1'b1;
			adc_ncs <= 1'b1;
			adc_sclk <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
				daq_pkg::CFG_IDLE: begin
					// changes during a frame are caught here afterwards
					if (mode_diff) begin
						mode_q <= adc_mode;
						ready <= 1'b0;
						adc_ncs <= 1'b0;
						div_cnt <= '0;
						bit_cnt <= '0;
						state <= daq_pkg::CFG_SHIFT;
					end
				end
				daq_pkg::CFG_SHIFT: begin
					if (half_done) begin
						div_cnt <= '0;
						adc_sclk <= ~adc_sclk;
						// falling sclk closes a bit
						if (adc_sclk) begin
							if (bit_cnt == BIT_W'(BITS - 1)) begin
								state <= daq_pkg::CFG_END;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				daq_pkg::CFG_END: begin
					// two cycles of hold before ncs rises
					if (div_cnt == DIV_W'(1)) begin
						adc_ncs <= 1'b1;
						ready <= 1'b1;
						div_cnt <= '0;
						state <= daq_pkg::CFG_IDLE;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				default: state <= daq_pkg::CFG_IDLE;
			endcase
		end
	end

	// data shifts while sclk goes low, msb first
	always_ff @(posedge sysclk) begin
		if (state == daq_pkg::CFG_IDLE && mode_diff) begin
			frame_sr <= frame_new;
		end else if (state == daq_pkg::CFG_SHIFT && half_done && adc_sclk) begin
			frame_sr <= {frame_sr[BITS-2:0], 1'b0};
		end
	end

	assign adc_sdio = frame_sr[BITS-1];

endmodule

`default_nettype wire

// File: hw/daq_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "daq_defines.svh"

module daq_ctrl_regs (
	input wire logic sysclk,
	input wire logic rst,
	input wire daq_pkg::spi_byte_t rx_byte,
	input wire logic rx_done,
	input wire logic ss,
	output daq_pkg::spi_byte_t tx_byte,
	input wire daq_pkg::adc_status_t adc_status,
	output daq_pkg::adc_mode_t adc_mode,
	output logic soft_rst,
	input wire logic pmt_trigger,
	output logic trigger_out
);

	daq_pkg::cmd_state_t state;
	// incoming byte seen as a command
	daq_pkg::spi_cmd_t cmd_new;
	// target of a pending write
	daq_pkg::reg_addr_t wr_addr;
	daq_pkg::adc_mode_t mode_reg;
	daq_pkg::spi_byte_t rd_data;
	logic trig_reg;
	logic srst_reg;
	logic trig_meta;
	logic [1:0] ss_sync;
	logic wr_known;
	logic rd_known;

	assign cmd_new = daq_pkg::spi_cmd_t'(rx_byte);

	// writable addresses, status only reads
	assign wr_known = cmd_new.addr inside {`DAQ_REG_ADC_MODE, `DAQ_REG_TRIGGER,
		`DAQ_REG_SOFT_RESET};
	assign rd_known = wr_known | (cmd_new.addr == `DAQ_REG_STATUS);

	// ------------------------------
	// read mux
	// ------------------------------
	always_comb begin
		// unused addresses read 0
		rd_data = '0;
		case (cmd_new.addr)
			`DAQ_REG_ADC_MODE: rd_data = mode_reg;
			`DAQ_REG_TRIGGER: rd_data = daq_pkg::spi_byte_t'(trig_reg);
			`DAQ_REG_SOFT_RESET: rd_data = daq_pkg::spi_byte_t'(srst_reg);
			// live ready levels
			`DAQ_REG_STATUS: rd_data = daq_pkg::spi_byte_t'(adc_status);
			default: rd_data = '0;
		endcase
	end

	// ss level into the sysclk domain
	always_ff @(posedge sysclk) begin
		if (rst) begin
			ss_sync <= '1;
		end else begin
			ss_sync <= {ss_sync[0], ss};
		end
	end

	// ------------------------------
	// command fsm and registers
	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (rst) begin
			state <= daq_pkg::CMD_IDLE;
			mode_reg <= `DAQ_ADC_MODE_DEFAULT;
			trig_reg <= 1'b0;
			srst_reg <= 1'b0;
			tx_byte <= '0;
		end else if (ss_sync[1]) begin
			// frame ended, drop any half command
			state <= daq_pkg::CMD_IDLE;
		end else if (rx_done) begin
			case (state)
				daq_pkg::CMD_IDLE: begin
					if (cmd_new.op == `DAQ_CMD_WRITE && wr_known) begin
						state <= daq_pkg::CMD_WRITE_DATA;
					end else if (cmd_new.op == `DAQ_CMD_READ) begin
						// goes out during the second byte
						tx_byte <= rd_data;
						if (rd_known) begin
							state <= daq_pkg::CMD_READ_DATA;
						end
					end
				end
				daq_pkg::CMD_WRITE_DATA: begin
					state <= daq_pkg::CMD_IDLE;
					case (wr_addr)
						`DAQ_REG_ADC_MODE: mode_reg <= rx_byte;
						`DAQ_REG_TRIGGER: trig_reg <= rx_byte[0];
						// clears itself through the merged reset
						`DAQ_REG_SOFT_RESET: srst_reg <= rx_byte[0];
						default: state <= daq_pkg::CMD_IDLE;
					endcase
				end
				// second byte of a read is a dummy
				daq_pkg::CMD_READ_DATA: state <= daq_pkg::CMD_IDLE;
				default: state <= daq_pkg::CMD_IDLE;
			endcase
		end
	end

	// address kept for the data byte
	always_ff @(posedge sysclk) begin
		if (rx_done && state == daq_pkg::CMD_IDLE) begin
			wr_addr <= cmd_new.addr;
		end
	end

	assign adc_mode = mode_reg;
	assign soft_rst = srst_reg;

	// ------------------------------
	// trigger path
	// ------------------------------
	// external pmt or soft trigger, two flops
	always_ff @(posedge sysclk) begin
		if (rst) begin
			trig_meta <= 1'b0;
			trigger_out <= 1'b0;
		end else begin
			trig_meta <= pmt_trigger | trig_reg;
			trigger_out <= trig_meta;
		end
	end

endmodule

`default_nettype wire

// File: hw/zynq_spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "daq_defines.svh"

module zynq_spi_slave (
	input wire logic sysclk,
	input wire logic rst,
	input wire logic ss,
	input wire logic sck,
	input wire logic mosi,
	output logic miso,
	input wire daq_pkg::spi_byte_t tx_byte,
	output daq_pkg::spi_byte_t rx_byte,
	output logic rx_done
);

	localparam int W = `DAQ_SPI_WORD;
	localparam int CNT_W = $clog2(W);

	// host lines after the synchronizers
	logic [2:0] sck_sync;
	logic [2:0] ss_sync;
	logic [1:0] mosi_sync;
	logic sck_rise;
	logic sck_fall;
	logic ss_fall;
	logic ss_active;
	logic last_bit;
	logic [CNT_W-1:0] bit_cnt;
	daq_pkg::spi_byte_t rx_sr;
	daq_pkg::spi_byte_t tx_sr;

	// ------------------------------
	// synchronizers
	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (rst) begin
			sck_sync <= '0;
			// ss idles high
			ss_sync <= '1;
			mosi_sync <= '0;
		end else begin
			sck_sync <= {sck_sync[1:0], sck};
			ss_sync <= {ss_sync[1:0], ss};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	// edges seen on the synced copies
	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign sck_fall = ~sck_sync[1] & sck_sync[2];
	assign ss_fall = ~ss_sync[1] & ss_sync[2];
	// ss is active low
	assign ss_active = ~ss_sync[1];
	assign last_bit = (bit_cnt == CNT_W'(W - 1));

	// ------------------------------
	// bit counter and byte strobe
	// ------------------------------
	always_ff @(posedge sysclk) begin
		if (rst) begin
			bit_cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (!ss_active) begin
				// realign on every new frame
				bit_cnt <= '0;
			end else if (sck_rise) begin
				if (last_bit) begin
					bit_cnt <= '0;
					rx_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// mosi sampled on rising sck, msb first
	always_ff @(posedge sysclk) begin
		if (ss_active && sck_rise) begin
			rx_sr <= {rx_sr[W-2:0], mosi_sync[1]};
			if (last_bit) begin
				rx_byte <= {rx_sr[W-2:0], mosi_sync[1]};
			end
		end
	end

	// miso shifts on falling sck
	// falling edge that closes a byte reloads the next word,
	// by then the register block has updated tx_byte
	always_ff @(posedge sysclk) begin
		if (ss_fall) begin
			tx_sr <= tx_byte;
		end else if (ss_active && sck_fall) begin
			if (bit_cnt == '0) begin
				tx_sr <= tx_byte;
			end else begin
				tx_sr <= {tx_sr[W-2:0], 1'b0};
			end
		end
	end

	assign miso = tx_sr[W-1];

endmodule

`default_nettype wire

// File: hw/daq_pkg.sv
`default_nettype none

`include "daq_defines.svh"

package daq_pkg;

	// ------------------------------
	// plain vectors
	// ------------------------------
	// one word on the host spi link
	typedef logic [`DAQ_SPI_WORD-1:0] spi_byte_t;
	typedef logic [`DAQ_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`DAQ_REG_OP_W-1:0] reg_op_t;
	// adc test mode value
	typedef logic [`DAQ_ADC_MODE_W-1:0] adc_mode_t;

	// ------------------------------
	// bundles
	// ------------------------------
	// command byte, address in the upper nibble
	typedef struct packed {
		reg_addr_t addr;
		reg_op_t op;
	} spi_cmd_t;

	// adc write frame, sent msb first
	typedef struct packed {
		// 0 for write
		logic rw;
		// 00 means one data byte
		logic [1:0] len;
		logic [`DAQ_ADC_ADDR_W-1:0] addr;
		adc_mode_t data;
	} adc_frame_t;

	// ready levels of both adc channels
	typedef struct packed {
		logic ready_b;
		logic ready_a;
	} adc_status_t;

	// ------------------------------
	// state machines
	// ------------------------------
	typedef enum logic [1:0] {CMD_IDLE, CMD_WRITE_DATA, CMD_READ_DATA} cmd_state_t;
	typedef enum logic [1:0] {CFG_IDLE, CFG_SHIFT, CFG_END} cfg_state_t;

endpackage

`default_nettype wire

// File: hw/daq_defines.svh
`ifndef DAQ_DEFINES_SVH
`define DAQ_DEFINES_SVH

// ------------------------------
// host spi link
// ------------------------------
`define DAQ_SPI_WORD 8
`define DAQ_REG_ADDR_W 4
`define DAQ_REG_OP_W 4

// register map
`define DAQ_REG_ADC_MODE 4'd6
`define DAQ_REG_TRIGGER 4'd10
`define DAQ_REG_SOFT_RESET 4'd12
// read only, bit 0 ready of adc a, bit 1 ready of adc b
`define DAQ_REG_STATUS 4'd13

// op nibble of the command byte
`define DAQ_CMD_WRITE 4'd1
`define DAQ_CMD_READ 4'd2

// ------------------------------
// octal adc configuration port
// ------------------------------
`define DAQ_ADC_MODE_W 8
`define DAQ_ADC_ADDR_W 13
// mode register value after reset
`define DAQ_ADC_MODE_DEFAULT 8'h09
// differs from the default, so every channel reconfigures after reset
`define DAQ_ADC_MODE_RESET 8'h39
// test mode register inside the adc
`define DAQ_ADC_MODE_ADDR 13'h00D
`define DAQ_ADC_FRAME_BITS 24
// sysclk cycles per half period of adc sclk
`define DAQ_ADC_SCLK_HALF 4

`endif
